//--- build.f
+incdir+include
source/debug_link_pkg.sv
source/mips_probe_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/run_control.sv
source/dump_sequencer.sv
source/debugger_unit.sv
sim/debugger_unit_tb.sv

//--- include/tb_serial_tasks.svh
`ifndef tb_serial_tasks_svh
`define tb_serial_tasks_svh

////////////////////////////////////////////////////////////
// serial link, one bit per clks_per_bit cycles
////////////////////////////////////////////////////////////

task automatic send_byte(input byte_t data);
	@(negedge clk);
	rx = 1'b0;
	repeat (clks_per_bit) @(negedge clk);
	// lsb first
	for (int i = 0; i < 8; i++)
	begin
		rx = data[i];
		repeat (clks_per_bit) @(negedge clk);
	end
	rx = 1'b1;
	repeat (clks_per_bit) @(negedge clk);
endtask

task automatic receive_byte(output byte_t data);
	// hunt for the start bit
	@(negedge clk);
	while (tx !== 1'b0)
		@(negedge clk);
	repeat (clks_per_bit / 2) @(negedge clk);
	assert (tx === 1'b0)
	else
	begin
		$display("start bit on tx ended before the middle of the bit");
		fail_run();
	end
	for (int i = 0; i < 8; i++)
	begin
		repeat (clks_per_bit) @(negedge clk);
		data[i] = tx;
	end
	repeat (clks_per_bit) @(negedge clk);
	assert (tx === 1'b1)
	else
	begin
		$display("Error: tx stop bit = 0x%h, expected 0x1", tx);
		fail_run();
	end
endtask

////////////////////////////////////////////////////////////
// expected dump from the driven probe values
////////////////////////////////////////////////////////////

// most significant byte first
task automatic push_word(input word_t w);
	for (int b = 3; b >= 0; b--)
		expected_dump.push_back(w[8*b +: 8]);
endtask

task automatic build_expected_dump();
	expected_dump.delete();
	for (int r = 0; r < num_regs; r++)
		push_word(regs[r]);
	push_word(if_probe.pc);
	push_word(if_probe.instruction);
	push_word(id_probe.pc_plus4);
	push_word(id_probe.instruction);
	push_word(id_probe.write_data);
	expected_dump.push_back({3'b000, id_probe.write_addr});
	// EX alu result sits inside the ID block
	push_word(ex_probe.alu_result);
	push_word(id_probe.reg_data1);
	push_word(id_probe.reg_data2);
	push_word(id_probe.sign_extend);
	expected_dump.push_back({3'b000, id_probe.rs});
	expected_dump.push_back({3'b000, id_probe.rt});
	expected_dump.push_back({3'b000, id_probe.rd});
	push_word(id_probe.pc_jump);
	push_word(id_probe.pc_branch);
	push_word(ex_probe.pc_plus4);
	push_word(ex_probe.reg_data1);
	push_word(ex_probe.reg_data2);
	push_word(ex_probe.sign_extend);
	expected_dump.push_back({3'b000, ex_probe.rt});
	expected_dump.push_back({3'b000, ex_probe.rd});
	expected_dump.push_back({7'b0000000, ex_probe.zero});
	push_word(ex_probe.alu_result);
	push_word(ex_probe.reg_data2_out);
	expected_dump.push_back({3'b000, ex_probe.rt_or_rd});
	push_word(mem_probe.address);
	push_word(mem_probe.write_data);
	push_word(mem_probe.read_data);
	push_word(wb_probe.mem_data);
	push_word(wb_probe.alu_result);
	push_word(wb_probe.write_data);
endtask

`endif

//--- sim/debugger_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module debugger_unit_tb
	import debug_link_pkg::*;
	import mips_probe_pkg::*;
();

	// one dump with its command byte
	localparam int dump_cycles    = (dump_bytes + 1) * (10 * clks_per_bit + 4);
	// six commands plus margin
	localparam int timeout_cycles = 8 * dump_cycles;

	logic       clk = 1'b0;
	logic       reset;
	logic       rx;
	logic       tx;
	byte_t      led;
	logic       ena_pip;
	word_t      pc_plus4;
	reg_file_t  regs;
	if_probe_t  if_probe;
	id_probe_t  id_probe;
	ex_probe_t  ex_probe;
	mem_probe_t mem_probe;
	wb_probe_t  wb_probe;

	byte_t expected_dump[$];
	int    cycle_count = 0;
	int    ena_high_cycles = 0;
	int    ena_rises = 0;
	int    ena_falls = 0;
	logic  ena_prev = 1'b0;

	debugger_unit debugger_unit_inst
	(
		.clk       (clk),
		.reset     (reset),
		.rx        (rx),
		.tx        (tx),
		.led       (led),
		.ena_pip   (ena_pip),
		.pc_plus4  (pc_plus4),
		.regs      (regs),
		.if_probe  (if_probe),
		.id_probe  (id_probe),
		.ex_probe  (ex_probe),
		.mem_probe (mem_probe),
		.wb_probe  (wb_probe)
	);

	`include "tb_serial_tasks.svh"

	always #4 clk = ~clk;

	// pipeline enable activity as seen before each edge
	always @(posedge clk)
	begin
		if (ena_pip === 1'b1)
			ena_high_cycles++;
		if (ena_pip === 1'b1 && ena_prev === 1'b0)
			ena_rises++;
		if (ena_pip === 1'b0 && ena_prev === 1'b1)
			ena_falls++;
		ena_prev = ena_pip;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= timeout_cycles)
		begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
			fail_run();
		end
	end

	task automatic fail_run();
		$display("Done: errors found");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			fail_run();
		end
	endtask

	function automatic reg_addr_t rand_addr();
		logic [31:0] r;
		r = $urandom();
		return r[reg_addr_w-1:0];
	endfunction

	task automatic randomize_probes();
		logic [31:0] r;
		for (int i = 0; i < num_regs; i++)
			regs[i] = $urandom();
		if_probe.pc            = $urandom();
		if_probe.instruction   = $urandom();
		id_probe.pc_plus4      = $urandom();
		id_probe.instruction   = $urandom();
		id_probe.write_data    = $urandom();
		id_probe.write_addr    = rand_addr();
		id_probe.reg_data1     = $urandom();
		id_probe.reg_data2     = $urandom();
		id_probe.sign_extend   = $urandom();
		id_probe.rs            = rand_addr();
		id_probe.rt            = rand_addr();
		id_probe.rd            = rand_addr();
		id_probe.pc_jump       = $urandom();
		id_probe.pc_branch     = $urandom();
		r = $urandom();
		ex_probe.pc_plus4      = $urandom();
		ex_probe.reg_data1     = $urandom();
		ex_probe.reg_data2     = $urandom();
		ex_probe.sign_extend   = $urandom();
		ex_probe.rt            = rand_addr();
		ex_probe.rd            = rand_addr();
		ex_probe.zero          = r[0];
		ex_probe.alu_result    = $urandom();
		ex_probe.reg_data2_out = $urandom();
		ex_probe.rt_or_rd      = rand_addr();
		mem_probe.address      = $urandom();
		mem_probe.write_data   = $urandom();
		mem_probe.read_data    = $urandom();
		wb_probe.mem_data      = $urandom();
		wb_probe.alu_result    = $urandom();
		wb_probe.write_data    = $urandom();
	endtask

	////////////////////////////////////////////////////////////
	// one host command and its dump
	////////////////////////////////////////////////////////////

	task automatic run_command(input byte_t cmd);
		byte_t got;
		build_expected_dump();
		@(negedge clk);
		ena_high_cycles = 0;
		ena_rises       = 0;
		ena_falls       = 0;
		send_byte(cmd);
		for (int i = 0; i < dump_bytes; i++)
		begin
			receive_byte(got);
			assert (got === expected_dump[i])
			else
			begin
				$display("Error: tx dump byte %0d = 0x%h, expected 0x%h",
					i, got, expected_dump[i]);
				fail_run();
			end
		end
		// rest of the last stop bit
		repeat (clks_per_bit) @(negedge clk);
		check_equal("led", led, cmd);
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic reset_values();
		repeat (20)
		begin
			@(negedge clk);
			check_equal("tx", tx, 1'b1);
			check_equal("ena_pip", ena_pip, 1'b0);
		end
		check_equal("led", led, 8'h00);
	endtask

	task automatic single_step();
		run_command(cmd_step);
		check_equal("ena_pip high cycles", ena_high_cycles, 1);
		check_equal("ena_pip", ena_pip, 1'b0);
	endtask

	task automatic continue_then_stop();
		run_command(cmd_continue);
		check_equal("ena_pip", ena_pip, 1'b1);
		check_equal("ena_pip rising edges", ena_rises, 1);
		check_equal("ena_pip falling edges", ena_falls, 0);
		run_command(8'ha5);
		check_equal("ena_pip", ena_pip, 1'b0);
		check_equal("ena_pip rising edges", ena_rises, 0);
	endtask

	task automatic new_probe_values();
		randomize_probes();
		run_command(8'h5c);
		check_equal("ena_pip rising edges", ena_rises, 0);
	endtask

	task automatic program_finish();
		run_command(cmd_continue);
		check_equal("ena_pip", ena_pip, 1'b1);
		@(negedge clk);
		pc_plus4 = pc_limit;
		// state goes finished first and enable drops on the next edge
		@(negedge clk);
		check_equal("ena_pip", ena_pip, 1'b1);
		@(negedge clk);
		check_equal("ena_pip", ena_pip, 1'b0);
		pc_plus4 = 32'h0000_0100;
		run_command(cmd_continue);
		check_equal("ena_pip", ena_pip, 1'b0);
		check_equal("ena_pip rising edges", ena_rises, 0);
	endtask

	initial
	begin
		int unsigned seed_state;
		seed_state = $urandom(63457);
		reset    = 1'b1;
		rx       = 1'b1;
		pc_plus4 = 32'h0000_0040;
		randomize_probes();
		repeat (10) @(negedge clk);
		reset = 1'b0;
		reset_values();
		single_step();
		continue_then_stop();
		new_probe_values();
		program_finish();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/debug_link_pkg.sv
`default_nettype none

package debug_link_pkg;

	//////////////////////////////////////////////////////////////
	// serial link
	//////////////////////////////////////////////////////////////

	// clock cycles per serial bit
	localparam int clks_per_bit = 16;

	typedef logic [7:0] byte_t;

	//////////////////////////////////////////////////////////////
	// debug protocol
	//////////////////////////////////////////////////////////////

	// host commands, any other byte stops the pipeline
	localparam byte_t cmd_step     = 8'h02;
	localparam byte_t cmd_continue = 8'h01;

	typedef enum logic [1:0]
	{
		stopped,
		step,
		running,
		finished
	} run_state_t;

	// registers, then stage probes with 5-bit fields one byte each
	localparam int dump_bytes = 228;

endpackage

`default_nettype wire

//--- source/debugger_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debugger_unit
	import debug_link_pkg::*;
	import mips_probe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic       tx,
	output byte_t      led,
	output logic       ena_pip,
	input  word_t      pc_plus4,
	input  reg_file_t  regs,
	input  if_probe_t  if_probe,
	input  id_probe_t  id_probe,
	input  ex_probe_t  ex_probe,
	input  mem_probe_t mem_probe,
	input  wb_probe_t  wb_probe
);

	logic  rx_valid;
	byte_t rx_data;
	logic  tx_start;
	byte_t tx_data;
	logic  tx_done;

	uart_rx uart_rx_inst
	(
		.clk      (clk),
		.reset    (reset),
		.rx       (rx),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

	uart_tx
	#(
		.clks_per_bit (clks_per_bit)
	)
	uart_tx_inst
	(
		.clk      (clk),
		.reset    (reset),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx       (tx),
		.tx_done  (tx_done)
	);

	// every received byte is a command and a dump request
	run_control run_control_inst
	(
		.clk      (clk),
		.reset    (reset),
		.rx_valid (rx_valid),
		.rx_data  (rx_data),
		.pc_plus4 (pc_plus4),
		.ena_pip  (ena_pip),
		.led      (led)
	);

	dump_sequencer dump_sequencer_inst
	(
		.clk       (clk),
		.reset     (reset),
		.rx_valid  (rx_valid),
		.regs      (regs),
		.if_probe  (if_probe),
		.id_probe  (id_probe),
		.ex_probe  (ex_probe),
		.mem_probe (mem_probe),
		.wb_probe  (wb_probe),
		.tx_done   (tx_done),
		.tx_start  (tx_start),
		.tx_data   (tx_data)
	);

endmodule

`default_nettype wire

//--- source/dump_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module dump_sequencer
	import debug_link_pkg::*;
	import mips_probe_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       rx_valid,
	input  reg_file_t  regs,
	input  if_probe_t  if_probe,
	input  id_probe_t  id_probe,
	input  ex_probe_t  ex_probe,
	input  mem_probe_t mem_probe,
	input  wb_probe_t  wb_probe,
	input  logic       tx_done,
	output logic       tx_start,
	output byte_t      tx_data
);

	localparam int snap_w = dump_bytes * 8;
	localparam int cnt_w  = $clog2(dump_bytes + 1);

	typedef enum logic [1:0]
	{
		s_idle,
		s_capture,
		s_send,
		s_wait
	} seq_state_t;

	seq_state_t        state;
	logic [cnt_w-1:0]  byte_cnt;
	logic [snap_w-1:0] snapshot;
	logic [snap_w-1:0] snap_next;

	// short fields go out as one byte, zero padded
	function automatic byte_t pad_addr(input reg_addr_t field);
		return {3'b000, field};
	endfunction

	//////////////////////////////////////////////////////////////
	// snapshot layout, byte 0 in the top bits
	//////////////////////////////////////////////////////////////

	assign snap_next =
	{
		regs,
		if_probe,
		// ID stage, with the EX alu result after write_addr
		id_probe.pc_plus4,
		id_probe.instruction,
		id_probe.write_data,
		pad_addr(id_probe.write_addr),
		ex_probe.alu_result,
		id_probe.reg_data1,
		id_probe.reg_data2,
		id_probe.sign_extend,
		pad_addr(id_probe.rs),
		pad_addr(id_probe.rt),
		pad_addr(id_probe.rd),
		id_probe.pc_jump,
		id_probe.pc_branch,
		// EX stage
		ex_probe.pc_plus4,
		ex_probe.reg_data1,
		ex_probe.reg_data2,
		ex_probe.sign_extend,
		pad_addr(ex_probe.rt),
		pad_addr(ex_probe.rd),
		{7'b0000000, ex_probe.zero},
		ex_probe.alu_result,
		ex_probe.reg_data2_out,
		pad_addr(ex_probe.rt_or_rd),
		mem_probe,
		wb_probe
	};

	//////////////////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////////////////

	// bytes received mid-dump are not queued
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state    <= s_idle;
			byte_cnt <= '0;
		end
		else
		begin
			case (state)
				s_idle:
				begin
					if (rx_valid)
						state <= s_capture;
				end
				s_capture:
				begin
					byte_cnt <= '0;
					state    <= s_send;
				end
				s_send:
				begin
					byte_cnt <= byte_cnt + 1'b1;
					state    <= s_wait;
				end
				s_wait:
				begin
					if (tx_done)
						state <= (byte_cnt == cnt_w'(dump_bytes)) ? s_idle : s_send;
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == s_capture)
			snapshot <= snap_next;
		else if (state == s_send)
			snapshot <= {snapshot[snap_w-9:0], 8'h00};
	end

	assign tx_start = (state == s_send);
	assign tx_data  = snapshot[snap_w-1 -: 8];

endmodule

`default_nettype wire

//--- source/mips_probe_pkg.sv
`default_nettype none

package mips_probe_pkg;

	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;

	typedef logic [word_w-1:0]     word_t;
	typedef logic [reg_addr_w-1:0] reg_addr_t;

	// incremented PC at the end of the program
	localparam word_t pc_limit = 32'd508;

	// register 0 sits in the top word
	typedef word_t [0:num_regs-1] reg_file_t;

	//////////////////////////////////////////////////////////////
	// stage probe points
	//////////////////////////////////////////////////////////////

	typedef struct packed
	{
		word_t pc;
		word_t instruction;
	} if_probe_t;

	typedef struct packed
	{
		word_t     pc_plus4;
		word_t     instruction;
		word_t     write_data;
		reg_addr_t write_addr;
		word_t     reg_data1;
		word_t     reg_data2;
		word_t     sign_extend;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		word_t     pc_jump;
		word_t     pc_branch;
	} id_probe_t;

	typedef struct packed
	{
		word_t     pc_plus4;
		word_t     reg_data1;
		word_t     reg_data2;
		word_t     sign_extend;
		reg_addr_t rt;
		reg_addr_t rd;
		logic      zero;
		word_t     alu_result;
		word_t     reg_data2_out;
		reg_addr_t rt_or_rd;
	} ex_probe_t;

	typedef struct packed
	{
		word_t address;
		word_t write_data;
		word_t read_data;
	} mem_probe_t;

	typedef struct packed
	{
		word_t mem_data;
		word_t alu_result;
		word_t write_data;
	} wb_probe_t;

endpackage

`default_nettype wire

//--- source/run_control.sv
`timescale 1ns/1ps
`default_nettype none

module run_control
	import debug_link_pkg::*;
	import mips_probe_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  rx_valid,
	input  byte_t rx_data,
	input  word_t pc_plus4,
	output logic  ena_pip,
	output byte_t led
);

	run_state_t state;
	run_state_t state_next;

	always_comb
	begin
		state_next = state;
		// end of program wins over a command in the same cycle
		if (pc_plus4 == pc_limit)
			state_next = finished;
		else if (state == finished)
			state_next = finished;
		else if (rx_valid)
		begin
			case (rx_data)
				cmd_step:     state_next = step;
				cmd_continue: state_next = running;
				default:      state_next = stopped;
			endcase
		end
		else if (state == step)
			state_next = stopped;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= stopped;
			ena_pip <= 1'b0;
			led     <= '0;
		end
		else
		begin
			state <= state_next;
			// one cycle behind the state, a step gives a single pulse
			ena_pip <= (state == step) || (state == running);
			if (rx_valid)
				led <= rx_data;
		end
	end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
	import debug_link_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  rx,
	output logic  rx_valid,
	output byte_t rx_data
);

	localparam int cnt_w = $clog2(2 * clks_per_bit);

	// counter end points within a bit
	localparam logic [cnt_w-1:0] half_bit = cnt_w'(clks_per_bit / 2 - 1);
	localparam logic [cnt_w-1:0] full_bit = cnt_w'(clks_per_bit - 1);
	localparam logic [cnt_w-1:0] stop_end = cnt_w'(clks_per_bit + clks_per_bit / 2 - 1);

	typedef enum logic [1:0]
	{
		s_idle,
		s_start,
		s_data,
		s_stop
	} rx_state_t;

	rx_state_t        state;
	logic [cnt_w-1:0] cnt;
	logic [2:0]       bit_idx;
	logic             rx_meta;
	logic             rx_sync;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rx_meta  <= 1'b1;
			rx_sync  <= 1'b1;
			state    <= s_idle;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end
		else
		begin
			rx_meta  <= rx;
			rx_sync  <= rx_meta;
			rx_valid <= 1'b0;
			case (state)
				s_idle:
				begin
					cnt <= '0;
					if (!rx_sync)
						state <= s_start;
				end
				s_start:
				begin
					// glitch shorter than half a bit goes back to idle
					if (cnt == half_bit)
					begin
						cnt     <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? s_idle : s_data;
					end
					else
						cnt <= cnt + 1'b1;
				end
				s_data:
				begin
					if (cnt == full_bit)
					begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= s_stop;
					end
					else
						cnt <= cnt + 1'b1;
				end
				s_stop:
				begin
					// runs on to the end of the stop bit
					if (cnt == stop_end)
					begin
						rx_valid <= 1'b1;
						state    <= s_idle;
					end
					else
						cnt <= cnt + 1'b1;
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	// lsb first, so shift in from the top
	always_ff @(posedge clk)
	begin
		if (state == s_data && cnt == full_bit)
			rx_data <= {rx_sync, rx_data[7:1]};
	end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx
#(
	parameter int clks_per_bit = 16
)
(
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx,
	output logic       tx_done
);

	localparam int cnt_w = $clog2(clks_per_bit);
	localparam logic [cnt_w-1:0] bit_end = cnt_w'(clks_per_bit - 1);

	typedef enum logic [1:0]
	{
		s_idle,
		s_start,
		s_data,
		s_stop
	} tx_state_t;

	tx_state_t        state;
	logic [cnt_w-1:0] cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shreg;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state   <= s_idle;
			cnt     <= '0;
			bit_idx <= '0;
			tx      <= 1'b1;
			tx_done <= 1'b0;
		end
		else
		begin
			tx_done <= 1'b0;
			case (state)
				s_idle:
				begin
					cnt     <= '0;
					bit_idx <= '0;
					if (tx_start)
					begin
						tx    <= 1'b0;
						state <= s_start;
					end
				end
				s_start:
				begin
					if (cnt == bit_end)
					begin
						cnt   <= '0;
						tx    <= shreg[0];
						state <= s_data;
					end
					else
						cnt <= cnt + 1'b1;
				end
				s_data:
				begin
					if (cnt == bit_end)
					begin
						cnt <= '0;
						if (bit_idx == 3'd7)
						begin
							tx    <= 1'b1;
							state <= s_stop;
						end
						else
						begin
							// next bit, shreg shifts on the same edge
							bit_idx <= bit_idx + 1'b1;
							tx      <= shreg[1];
						end
					end
					else
						cnt <= cnt + 1'b1;
				end
				s_stop:
				begin
					if (cnt == bit_end)
					begin
						tx_done <= 1'b1;
						state   <= s_idle;
					end
					else
						cnt <= cnt + 1'b1;
				end
				default:
					state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == s_idle && tx_start)
			shreg <= tx_data;
		else if (state == s_data && cnt == bit_end)
			shreg <= {1'b0, shreg[7:1]};
	end

endmodule

`default_nettype wire
